/* tb.f */
rtl/cp0Pkg.sv
rtl/tlbPkg.sv
rtl/cp0Ifs.sv
rtl/cp0Regs.sv
rtl/tlbArray.sv
rtl/excVector.sv
rtl/cp0Top.sv
sim/cp0Top_assertions.sv
sim/cp0Tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module cp0Tb -o cp0Sim \
    && ./obj_dir/cp0Sim | tee /dev/stderr | grep -q "TESTS PASSED" \
    && exit 0 || exit 1

/* sim/cp0Tb.sv */
`timescale 1ns/100ps

module cp0Tb;
    import cp0Pkg::*;
    import tlbPkg::*;

    localparam int tlbEntries = 8;
    localparam int maxCycles  = 2000;                   // tests need about 300 cycles

    logic        clock;
    logic        arstN;
    logic        issued;
    logic        mtc0;
    regAddrT     regAddr;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic        tlbwi;
    vpnT         lookupVpn;
    logic        lookupLoad;
    logic        lookupStore;
    logic        stall;
    pfnT         pfn;
    logic        pfnValid;
    tlbFaultT    fault;
    logic [5:0]  ints;
    logic        nmi;
    logic        excActive;
    excCodeT     excCode;
    logic        refill;
    logic [31:0] restartPc;
    logic        eret;
    logic        excPcSel;
    logic [31:0] excPc;
    logic        kernelMode;
    logic        enabledInt;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests  = 0;

    cp0Top #(.tlbEntries(tlbEntries)) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;                     // 40 ns period
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles == maxCycles);
        $display("timeout: run still busy after %0d cycles", maxCycles);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic compareWord(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic comparePfn(string name, pfnT got, pfnT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%05h expected 0x%05h", name, got, exp);
        end
    endtask

    task automatic compareFault(string name, tlbFaultT got, tlbFaultT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finishTest(string name, int errBefore);
        tests++;
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errBefore);
        end
    endtask

    // pfn 25:6, c 5:3, d 2, v 1
    function automatic logic [31:0] makeLo(pfnT p, logic d, logic v);
        return {6'b0, p, 3'b0, d, v, 1'b0};
    endfunction

    task automatic writeReg(regAddrT addr, logic [31:0] data);
        @(posedge clock);
        issued    <= 1'b1;
        mtc0      <= 1'b1;
        regAddr   <= addr;
        writeData <= data;
        @(posedge clock);                               // register takes it here
        issued <= 1'b0;
        mtc0   <= 1'b0;
    endtask

    task automatic checkReg(string name, regAddrT addr, logic [31:0] exp);
        @(posedge clock);
        regAddr <= addr;
        @(negedge clock);                               // mfc0 is combinational
        compareWord(name, readData, exp);
    endtask

    task automatic loadEntry(int idx, vpn2T vpn2, logic [31:0] lo0, logic [31:0] lo1);
        writeReg(regIndex, 32'(idx));
        writeReg(regEntryHi, {vpn2, 13'b0});
        writeReg(regEntryLo0, lo0);
        writeReg(regEntryLo1, lo1);
        @(posedge clock);
        issued <= 1'b1;
        tlbwi  <= 1'b1;
        @(posedge clock);
        issued <= 1'b0;
        tlbwi  <= 1'b0;
    endtask

    task automatic lookup(vpnT vpn, logic store);
        @(posedge clock);
        lookupVpn   <= vpn;
        lookupLoad  <= ~store;
        lookupStore <= store;
        @(posedge clock);                               // result register loads
        lookupLoad  <= 1'b0;
        lookupStore <= 1'b0;
        @(negedge clock);
    endtask

    task automatic expectHit(string name, vpnT vpn, logic store, pfnT expPfn);
        lookup(vpn, store);
        comparePfn({name, " pfn"}, pfn, expPfn);
        compareBit({name, " pfnValid"}, pfnValid, 1'b1);
        compareFault({name, " fault"}, fault, faultNone);
    endtask

    task automatic expectFault(string name, vpnT vpn, logic store, tlbFaultT expFault);
        lookup(vpn, store);
        compareBit({name, " pfnValid"}, pfnValid, 1'b0);
        compareFault({name, " fault"}, fault, expFault);
    endtask

    task automatic takeException(excCodeT code, logic isRefill, logic [31:0] pc,
                                 logic [31:0] expVec);
        @(posedge clock);
        excActive <= 1'b1;
        excCode   <= code;
        refill    <= isRefill;
        restartPc <= pc;
        @(negedge clock);
        compareBit("excPcSel", excPcSel, 1'b1);
        compareWord("excPc", excPc, expVec);
        @(posedge clock);                               // epc exl cause update here
        excActive <= 1'b0;
        refill    <= 1'b0;
    endtask

    task automatic takeEret(logic [31:0] expPc);
        @(posedge clock);
        eret   <= 1'b1;
        issued <= 1'b1;
        @(negedge clock);
        compareBit("excPcSel", excPcSel, 1'b1);
        compareWord("excPc", excPc, expPc);
        @(posedge clock);
        eret   <= 1'b0;
        issued <= 1'b0;
    endtask

    task automatic checkInt(string name, logic exp);
        @(negedge clock);
        compareBit(name, enabledInt, exp);
    endtask

    task automatic testReset();
        int e0;
        e0 = errors;
        repeat (16) @(posedge clock);
        arstN <= 1'b1;
        @(negedge clock);
        compareBit("excPcSel", excPcSel, 1'b1);         // boot redirect
        compareWord("excPc", excPc, 32'hBFC0_0000);
        compareBit("kernelMode", kernelMode, 1'b1);
        compareBit("pfnValid", pfnValid, 1'b0);
        compareFault("fault", fault, faultNone);
        compareBit("enabledInt", enabledInt, 1'b0);
        @(negedge clock);
        compareBit("excPcSel", excPcSel, 1'b0);         // one cycle only
        checkReg("status", regStatus, 32'h0040_0004);   // bev erl
        finishTest("reset", e0);
    endtask

    task automatic testRegs();
        int e0;
        e0 = errors;
        writeReg(regEntryHi, 32'hFFFF_FFFF);
        checkReg("entryHi", regEntryHi, 32'hFFFF_E000);    // vpn2 only
        writeReg(regEntryLo0, 32'hFFFF_FFFF);
        checkReg("entryLo0", regEntryLo0, 32'h03FF_FFFE);
        writeReg(regIndex, 32'hFFFF_FFFF);
        checkReg("index", regIndex, 32'(tlbEntries - 1));
        writeReg(regStatus, 32'hFFFF_FFFF);
        checkReg("status", regStatus, 32'h0040_FF17);
        writeReg(regStatus, 32'h0040_0004);
        checkReg("unimplemented", 5'd7, 32'h0);
        finishTest("registers", e0);
    endtask

    task automatic testLookup();
        int          e0;
        vpn2T        vpn2s [4];
        pfnT         evenPfn [4];
        pfnT         oddPfn [4];
        logic [31:0] r;
        vpnT         missVpn;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            r          = $urandom;
            vpn2s[i]   = {r[15:0], 3'(i)};             // low bits keep pairs apart
            r          = $urandom;
            evenPfn[i] = r[19:0];
            r          = $urandom;
            oddPfn[i]  = r[19:0];
            loadEntry(i, vpn2s[i], makeLo(evenPfn[i], 1'b1, 1'b1),
                      makeLo(oddPfn[i], 1'b1, 1'b1));
        end
        for (int i = 0; i < 4; i++) begin
            expectHit("even load", {vpn2s[i], 1'b0}, 1'b0, evenPfn[i]);
            expectHit("odd store", {vpn2s[i], 1'b1}, 1'b1, oddPfn[i]);
        end
        r       = $urandom;
        missVpn = {r[15:0], 3'd7, 1'b0};                // pair never written
        expectFault("miss", missVpn, 1'b0, faultRefill);
        @(posedge clock);
        lookupVpn  <= {vpn2s[0], 1'b0};
        lookupLoad <= 1'b1;
        @(posedge clock);
        stall     <= 1'b1;                              // freeze the hit
        lookupVpn <= missVpn;
        @(posedge clock);
        @(negedge clock);
        comparePfn("held pfn", pfn, evenPfn[0]);
        compareBit("held pfnValid", pfnValid, 1'b1);
        compareFault("held fault", fault, faultNone);
        @(posedge clock);
        stall      <= 1'b0;
        lookupLoad <= 1'b0;
        finishTest("lookup", e0);
    endtask

    task automatic testFaults();
        int   e0;
        vpn2T vpn2;
        e0   = errors;
        vpn2 = {16'hABCD, 3'd4};
        loadEntry(4, vpn2, makeLo(20'h11111, 1'b1, 1'b0),     // even page not valid
                  makeLo(20'h22222, 1'b0, 1'b1));             // odd page clean
        expectFault("invalid", {vpn2, 1'b0}, 1'b0, faultInvalid);
        expectFault("modified", {vpn2, 1'b1}, 1'b1, faultModified);
        expectHit("clean load", {vpn2, 1'b1}, 1'b0, 20'h22222);
        finishTest("faults", e0);
    endtask

    task automatic testExceptions();
        int e0;
        e0 = errors;
        writeReg(regStatus, 32'h0);                     // normal vectors, erl clear
        takeException(5'd4, 1'b0, 32'h0040_1000, 32'h8000_0180);
        checkReg("epc", regEpc, 32'h0040_1000);
        checkReg("status", regStatus, 32'h0000_0002);   // exl
        checkReg("cause", regCause, 32'h0000_0010);     // code 4
        takeException(excTlbL, 1'b1, 32'h0040_2000, 32'h8000_0180);  // nested refill
        checkReg("epc kept", regEpc, 32'h0040_1000);
        takeEret(32'h0040_1000);
        checkReg("status", regStatus, 32'h0);
        takeException(excTlbS, 1'b1, 32'h0040_3000, 32'h8000_0000);
        checkReg("epc", regEpc, 32'h0040_3000);
        checkReg("cause", regCause, 32'h0000_000C);     // tlbs
        takeEret(32'h0040_3000);
        writeReg(regCause, 32'h0080_0000);              // iv
        takeException(excInt, 1'b0, 32'h0040_4000, 32'h8000_0200);
        takeEret(32'h0040_4000);
        checkReg("status", regStatus, 32'h0);
        finishTest("exceptions", e0);
    endtask

    task automatic testInterrupts();
        int e0;
        e0 = errors;
        @(posedge clock);
        ints <= 6'b000100;                              // ip4 up
        writeReg(regStatus, 32'h0000_0001);             // ie, all masked
        checkInt("masked", 1'b0);
        writeReg(regStatus, 32'h0000_1001);             // im4
        checkInt("enabled", 1'b1);
        writeReg(regStatus, 32'h0000_1011);             // user mode
        checkInt("user mode", 1'b1);
        compareBit("kernelMode", kernelMode, 1'b0);
        writeReg(regStatus, 32'h0000_0801);             // im3 only
        checkInt("other line", 1'b0);
        writeReg(regStatus, 32'h0000_1013);             // exl forces kernel
        checkInt("exl set", 1'b0);
        compareBit("kernelMode exl", kernelMode, 1'b1);
        writeReg(regStatus, 32'h0000_1005);
        checkInt("erl set", 1'b0);
        writeReg(regStatus, 32'h0000_1000);
        checkInt("ie clear", 1'b0);
        @(posedge clock);
        ints <= 6'b0;
        finishTest("interrupts", e0);
    endtask

    initial begin
        arstN       = 1'b0;
        issued      = 1'b0;
        mtc0        = 1'b0;
        regAddr     = '0;
        writeData   = '0;
        tlbwi       = 1'b0;
        lookupVpn   = '0;
        lookupLoad  = 1'b0;
        lookupStore = 1'b0;
        stall       = 1'b0;
        ints        = '0;
        nmi         = 1'b0;
        excActive   = 1'b0;
        excCode     = '0;
        refill      = 1'b0;
        restartPc   = '0;
        eret        = 1'b0;
        void'($urandom(32'h09366895));
        testReset();
        testRegs();
        testLookup();
        testFaults();
        testExceptions();
        testInterrupts();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/cp0Top_assertions.sv */
`timescale 1ns/100ps

module cp0Top_assertions (
    input logic             clock,
    input logic             arstN,
    input logic             excActive,
    input logic             excPcSel,
    input logic             lookupStore,
    input logic             stall,
    input logic             pfnValid,
    input tlbPkg::tlbFaultT fault
);
    import tlbPkg::*;

    // any w1 exception redirects fetch in the same cycle
    excRedirect: assert property (@(posedge clock) disable iff (!arstN)
        excActive |-> excPcSel)
        else $error("excActive high without excPcSel");

    // held results are exempt, a fresh modified fault needs a store
    modifiedNeedsStore: assert property (@(posedge clock) disable iff (!arstN)
        (fault == faultModified && !$past(stall)) |-> $past(lookupStore))
        else $error("faultModified without a store lookup");

    noValidWithFault: assert property (@(posedge clock) disable iff (!arstN)
        !(pfnValid && fault != faultNone))
        else $error("pfnValid together with a fault");

endmodule

bind cp0Top cp0Top_assertions asrt_i (
    .clock       (clock),
    .arstN       (arstN),
    .excActive   (excActive),
    .excPcSel    (excPcSel),
    .lookupStore (lookupStore),
    .stall       (stall),
    .pfnValid    (pfnValid),
    .fault       (fault)
);

/* rtl/cp0Top.sv */
`timescale 1ns/100ps

module cp0Top #(
    parameter int tlbEntries = 8                        // power of two, 2 to 16
) (
    input  logic             clock,
    input  logic             arstN,
    input  logic             issued,                    // qualifies mtc0 tlbwi eret
    input  logic             mtc0,
    input  cp0Pkg::regAddrT  regAddr,
    input  logic [31:0]      writeData,
    output logic [31:0]      readData,
    input  logic             tlbwi,
    input  tlbPkg::vpnT      lookupVpn,
    input  logic             lookupLoad,
    input  logic             lookupStore,
    input  logic             stall,
    output tlbPkg::pfnT      pfn,
    output logic             pfnValid,
    output tlbPkg::tlbFaultT fault,
    input  logic [5:0]       ints,
    input  logic             nmi,
    input  logic             excActive,
    input  cp0Pkg::excCodeT  excCode,
    input  logic             refill,
    input  logic [31:0]      restartPc,
    input  logic             eret,
    output logic             excPcSel,
    output logic [31:0]      excPc,
    output logic             kernelMode,
    output logic             enabledInt
);

    tlbWriteIf #(.tlbEntries(tlbEntries)) tlbWrBus ();  // regs to tlb
    excStateIf excStBus ();                             // regs to vector select

    cp0Regs #(.tlbEntries(tlbEntries)) regs_i (
        .clock      (clock),
        .arstN      (arstN),
        .issued     (issued),
        .mtc0       (mtc0),
        .regAddr    (regAddr),
        .writeData  (writeData),
        .readData   (readData),
        .tlbwi      (tlbwi),
        .ints       (ints),
        .excActive  (excActive),
        .nmi        (nmi),
        .excCode    (excCode),
        .restartPc  (restartPc),
        .eret       (eret),
        .kernelMode (kernelMode),
        .enabledInt (enabledInt),
        .tlbWr      (tlbWrBus.regs),
        .excSt      (excStBus.regs)
    );

    tlbArray #(.tlbEntries(tlbEntries)) tlb_i (
        .clock       (clock),
        .arstN       (arstN),
        .lookupVpn   (lookupVpn),
        .lookupLoad  (lookupLoad),
        .lookupStore (lookupStore),
        .stall       (stall),
        .pfn         (pfn),
        .pfnValid    (pfnValid),
        .fault       (fault),
        .tlbWr       (tlbWrBus.tlb)
    );

    excVector vec_i (
        .clock     (clock),
        .arstN     (arstN),
        .excActive (excActive),
        .nmi       (nmi),
        .excCode   (excCode),
        .refill    (refill),
        .eret      (eret),
        .issued    (issued),
        .excPcSel  (excPcSel),
        .excPc     (excPc),
        .excSt     (excStBus.vec)
    );

endmodule

/* rtl/excVector.sv */
`timescale 1ns/100ps

module excVector (
    input  logic            clock,
    input  logic            arstN,
    input  logic            excActive,                  // exception or interrupt in w1
    input  logic            nmi,
    input  cp0Pkg::excCodeT excCode,
    input  logic            refill,                     // tlb miss flavour of excCode
    input  logic            eret,
    input  logic            issued,
    output logic            excPcSel,                   // pc override for fetch
    output logic [31:0]     excPc,
    excStateIf.vec          excSt
);
    import cp0Pkg::*;

    logic        bootPending;                           // first cycle out of reset
    logic        retEn;
    logic [31:0] vecBase;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            bootPending <= 1'b1;
        end else begin
            bootPending <= 1'b0;
        end
    end

    assign retEn               = eret & issued;
    assign excSt.refillPending = excActive & refill & ~nmi;
    assign vecBase             = excSt.bev ? vecBaseBoot : vecBaseNormal;
    assign excPcSel            = bootPending | excActive | retEn;

    always_comb begin
        if (bootPending || (excActive && nmi)) begin
            excPc = vecReset;
        end else if (retEn) begin
            excPc = excSt.erl ? excSt.errorEpc : excSt.epc;
        end else if (excSt.refillPending && !excSt.exl) begin
            excPc = vecBase + offRefill;                // nested refill goes general
        end else if (excCode == excInt && excSt.iv) begin
            excPc = vecBase + offInterrupt;
        end else begin
            excPc = vecBase + offGeneral;
        end
    end

endmodule

/* rtl/tlbArray.sv */
`timescale 1ns/100ps

module tlbArray #(
    parameter int tlbEntries = 8
) (
    input  logic             clock,
    input  logic             arstN,
    input  tlbPkg::vpnT      lookupVpn,                 // data side, cycle n
    input  logic             lookupLoad,
    input  logic             lookupStore,
    input  logic             stall,                     // hold the result register
    output tlbPkg::pfnT      pfn,                       // cycle n+1
    output logic             pfnValid,
    output tlbPkg::tlbFaultT fault,
    tlbWriteIf.tlb           tlbWr
);
    import tlbPkg::*;

    logic [tlbEntries-1:0] used;                        // entry written since reset
    vpn2T                  vpn2Mem [tlbEntries];
    entryLoT               lo0Mem  [tlbEntries];
    entryLoT               lo1Mem  [tlbEntries];
    logic                  hit;
    entryLoT               hitLo;                       // half picked by vpn bit 0
    logic                  access;
    logic                  validNext;
    tlbFaultT              faultNext;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            used <= '0;                                 // nothing can match
        end else if (tlbWr.write) begin
            used[tlbWr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (tlbWr.write) begin
            vpn2Mem[tlbWr.index] <= tlbWr.vpn2;
            lo0Mem[tlbWr.index]  <= tlbWr.lo0;
            lo1Mem[tlbWr.index]  <= tlbWr.lo1;
        end
    end

    // fully associative match over all slots
    always_comb begin
        hit   = 1'b0;
        hitLo = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (used[i] && vpn2Mem[i] == lookupVpn[vpnBits-1:1]) begin
                hit   = 1'b1;
                hitLo = lookupVpn[0] ? lo1Mem[i] : lo0Mem[i];
            end
        end
    end

    assign access = lookupLoad | lookupStore;

    always_comb begin
        validNext = 1'b0;
        faultNext = faultNone;
        if (access) begin
            if (!hit) begin
                faultNext = faultRefill;
            end else if (!hitLo.v) begin
                faultNext = faultInvalid;
            end else if (lookupStore && !hitLo.d) begin
                faultNext = faultModified;              // clean page is read only
            end else begin
                validNext = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pfnValid <= 1'b0;
            fault    <= faultNone;
        end else if (!stall) begin
            pfnValid <= validNext;
            fault    <= faultNext;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            pfn <= hitLo.pfn;                           // zero on a miss
        end
    end

endmodule

/* rtl/cp0Regs.sv */
`timescale 1ns/100ps

module cp0Regs #(
    parameter int tlbEntries = 8                        // sizes index
) (
    input  logic            clock,
    input  logic            arstN,
    input  logic            issued,                     // w1 instruction commits
    input  logic            mtc0,
    input  cp0Pkg::regAddrT regAddr,                    // shared by mtc0 and mfc0
    input  logic [31:0]     writeData,
    output logic [31:0]     readData,                   // mfc0 result, combinational
    input  logic            tlbwi,
    input  logic [5:0]      ints,                       // hw lines ip7..ip2
    input  logic            excActive,
    input  logic            nmi,
    input  cp0Pkg::excCodeT excCode,
    input  logic [31:0]     restartPc,
    input  logic            eret,
    output logic            kernelMode,
    output logic            enabledInt,                 // an unmasked line is up
    tlbWriteIf.regs         tlbWr,
    excStateIf.regs         excSt
);
    import cp0Pkg::*;
    import tlbPkg::*;

    localparam int idxBits = $clog2(tlbEntries);

    logic [idxBits-1:0] indexReg;
    entryLoT            entryLo0;
    entryLoT            entryLo1;
    vpn2T               entryHi;
    statusT             status;
    logic               causeIv;
    excCodeT            causeExc;
    logic [31:0]        epc;
    logic [31:0]        errorEpc;
    logic               wrEn;                           // mtc0 that really commits
    logic               retEn;
    excCodeT            codeNext;                       // code recorded on entry

    function automatic entryLoT loFromWord(logic [31:0] w);
        entryLoT lo;
        lo      = entryLoT'(w[25:0]);
        lo.rsvd = 1'b0;                                 // no global bit
        return lo;
    endfunction

    assign wrEn  = mtc0 & issued & ~excActive;          // exception wins the cycle
    assign retEn = eret & issued;

    // a refill always records a tlb load or store code
    assign codeNext = !excSt.refillPending   ? excCode :
                      (excCode == excTlbS)   ? excTlbS : excTlbL;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            status   <= statusT'(statusResetVal);       // kernel via erl
            causeIv  <= 1'b0;
            causeExc <= excInt;
        end else if (excActive) begin
            if (nmi) begin
                status.erl <= 1'b1;
                status.bev <= 1'b1;
            end else begin
                status.exl <= 1'b1;
                causeExc   <= codeNext;
            end
        end else if (retEn) begin
            if (status.erl) begin
                status.erl <= 1'b0;                     // nmi/reset return first
            end else begin
                status.exl <= 1'b0;
            end
        end else if (wrEn) begin
            if (regAddr == regStatus) begin
                status <= statusT'(writeData & statusWriteMask);
            end
            if (regAddr == regCause) begin
                causeIv <= writeData[causeIvBit];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wrEn) begin
            case (regAddr)
                regIndex:    indexReg <= writeData[idxBits-1:0];
                regEntryLo0: entryLo0 <= loFromWord(writeData);
                regEntryLo1: entryLo1 <= loFromWord(writeData);
                regEntryHi:  entryHi  <= writeData[31:13];  // asid field dropped
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (excActive && !nmi && !status.exl) begin
            epc <= restartPc;                           // nested entry keeps old epc
        end else if (wrEn && regAddr == regEpc) begin
            epc <= writeData;
        end
        if (excActive && nmi) begin
            errorEpc <= restartPc;
        end else if (wrEn && regAddr == regErrorEpc) begin
            errorEpc <= writeData;
        end
    end

    always_comb begin
        case (regAddr)
            regIndex:    readData = {{(32-idxBits){1'b0}}, indexReg};
            regEntryLo0: readData = {6'b0, entryLo0};
            regEntryLo1: readData = {6'b0, entryLo1};
            regEntryHi:  readData = {entryHi, 13'b0};
            regStatus:   readData = status;
            regCause:    readData = {8'b0, causeIv, 7'b0, ints, 3'b0, causeExc, 2'b0};
            regEpc:      readData = epc;
            regErrorEpc: readData = errorEpc;
            default:     readData = '0;                 // unimplemented
        endcase
    end

    assign kernelMode = ~status.um | status.exl | status.erl;
    assign enabledInt = status.ie & ~status.exl & ~status.erl & |(ints & status.im[7:2]);

    assign tlbWr.write = tlbwi & issued;
    assign tlbWr.index = indexReg;
    assign tlbWr.vpn2  = entryHi;
    assign tlbWr.lo0   = entryLo0;
    assign tlbWr.lo1   = entryLo1;

    assign excSt.exl      = status.exl;
    assign excSt.erl      = status.erl;
    assign excSt.bev      = status.bev;
    assign excSt.iv       = causeIv;
    assign excSt.epc      = epc;
    assign excSt.errorEpc = errorEpc;

endmodule

/* rtl/cp0Ifs.sv */
`timescale 1ns/100ps

// tlbwi path from the register file into the entry store
interface tlbWriteIf #(
    parameter int tlbEntries = 8
);
    import tlbPkg::*;

    logic                          write;               // one-cycle strobe
    logic [$clog2(tlbEntries)-1:0] index;               // from the index register
    vpn2T                          vpn2;                // from entryhi
    entryLoT                       lo0;                 // even page
    entryLoT                       lo1;                 // odd page

    modport regs (output write, index, vpn2, lo0, lo1);
    modport tlb  (input  write, index, vpn2, lo0, lo1);

endinterface

// status bits and return addresses the vector selector needs
interface excStateIf;

    logic        exl;
    logic        erl;
    logic        bev;
    logic        iv;                                    // cause.iv
    logic [31:0] epc;
    logic [31:0] errorEpc;
    logic        refillPending;                         // current w1 event is a refill

    modport regs (output exl, erl, bev, iv, epc, errorEpc, input refillPending);
    modport vec  (input exl, erl, bev, iv, epc, errorEpc, output refillPending);

endinterface

/* rtl/tlbPkg.sv */
package tlbPkg;

    localparam int vpnBits = 20;                        // 4 KiB pages in a 32-bit space
    localparam int pfnBits = 20;                        // 32-bit physical space

    typedef logic [vpnBits-1:0] vpnT;
    typedef logic [pfnBits-1:0] pfnT;
    typedef logic [vpnBits-2:0] vpn2T;                  // even/odd pair number

    // entrylo as seen by software
    typedef struct packed {
        pfnT        pfn;                                // 25:6
        logic [2:0] c;                                  // 5:3 cache attribute
        logic       d;                                  // 2 dirty means writable
        logic       v;                                  // 1 valid
        logic       rsvd;                               // 0 global bit slot, reads zero
    } entryLoT;

    typedef enum logic [1:0] {
        faultNone,
        faultRefill,                                    // no entry matched
        faultInvalid,                                   // matched but v clear
        faultModified                                   // store with d clear
    } tlbFaultT;

endpackage

/* rtl/cp0Pkg.sv */
package cp0Pkg;

    typedef logic [4:0] regAddrT;                       // cp0 register number (rd field)

    localparam regAddrT regIndex    = 5'd0;             // tlb slot for tlbwi
    localparam regAddrT regEntryLo0 = 5'd2;             // even page mapping
    localparam regAddrT regEntryLo1 = 5'd3;             // odd page mapping
    localparam regAddrT regEntryHi  = 5'd10;            // vpn2 only
    localparam regAddrT regStatus   = 5'd12;
    localparam regAddrT regCause    = 5'd13;
    localparam regAddrT regEpc      = 5'd14;
    localparam regAddrT regErrorEpc = 5'd30;            // nmi return address

    typedef logic [4:0] excCodeT;

    localparam excCodeT excInt  = 5'd0;
    localparam excCodeT excMod  = 5'd1;                 // store to clean page
    localparam excCodeT excTlbL = 5'd2;                 // load or fetch miss/invalid
    localparam excCodeT excTlbS = 5'd3;                 // store miss/invalid

    localparam logic [31:0] vecReset      = 32'hBFC0_0000; // reset and nmi entry
    localparam logic [31:0] vecBaseBoot   = 32'hBFC0_0200; // bev set
    localparam logic [31:0] vecBaseNormal = 32'h8000_0000; // bev clear
    localparam logic [31:0] offRefill     = 32'h0000_0000;
    localparam logic [31:0] offGeneral    = 32'h0000_0180;
    localparam logic [31:0] offInterrupt  = 32'h0000_0200; // only with cause.iv

    typedef struct packed {
        logic [8:0] rsvd31;                             // 31:23
        logic       bev;                                // 22 boot vectors
        logic [5:0] rsvd21;                             // 21:16
        logic [7:0] im;                                 // 15:8 interrupt mask
        logic [2:0] rsvd7;                              // 7:5
        logic       um;                                 // 4 user mode
        logic       rsvd3;                              // 3
        logic       erl;                                // 2 error level
        logic       exl;                                // 1 exception level
        logic       ie;                                 // 0 global int enable
    } statusT;

    localparam logic [31:0] statusWriteMask = 32'h0040_FF17; // bev im um erl exl ie
    localparam logic [31:0] statusResetVal  = 32'h0040_0004; // bev and erl set

    localparam int causeIvBit = 23;                     // only writable cause bit

endpackage
